/* backend.f */
+incdir+test
hdl/isa_pkg.sv
hdl/pipeline_pkg.sv
hdl/dispatch_regfile_if.sv
hdl/regfile.sv
hdl/dispatch.sv
hdl/execute.sv
hdl/mem_stage.sv
hdl/backend_top.sv
test/tb_backend_top.sv

/* Bender.yml */
package:
  name: backend

sources:
  - hdl/isa_pkg.sv
  - hdl/pipeline_pkg.sv
  - hdl/dispatch_regfile_if.sv
  - hdl/regfile.sv
  - hdl/dispatch.sv
  - hdl/execute.sv
  - hdl/mem_stage.sv
  - hdl/backend_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_backend_top.sv

/* test/backend_model.svh */
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

typedef struct packed {
    int        due;
    reg_addr_t addr;
    bus32_t    data;
} wb_entry_t;

bus32_t    model_regs [32];
bus32_t    model_mem [DATA_WORDS];
logic      ex_load_valid;  // A load sits in execute this cycle.
reg_addr_t ex_load_dest;
wb_entry_t wb_queue [$];   // Expected write-backs in program order.

task automatic model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    foreach (model_mem[i]) begin
        model_mem[i] = '0;
    end
    ex_load_valid = 1'b0;
    ex_load_dest  = '0;
    wb_queue.delete();
endtask

function automatic bus32_t src_value(input logic en, input reg_addr_t addr);
    if (!en || addr == 5'd0) begin
        return '0;
    end
    return model_regs[addr];
endfunction

function automatic bus32_t operand_b(input id_dispatch_t d);
    return d.reg2_read_en ? src_value(1'b1, d.reg2_read_addr) : d.imm;
endfunction

function automatic int unsigned word_index(input bus32_t addr);
    return (addr >> 2) % DATA_WORDS;
endfunction

function automatic bus32_t branch_target(input id_dispatch_t d);
    bus32_t offs16;
    bus32_t offs26;
    offs16 = {{14{d.inst[25]}}, d.inst[25:10], 2'b00};
    offs26 = {{4{d.inst[9]}}, d.inst[9:0], d.inst[25:10], 2'b00};
    case (d.aluop)
        ALU_B, ALU_BL: return d.pc + offs26;
        ALU_JIRL:      return src_value(d.reg1_read_en, d.reg1_read_addr) + offs16;
        default:       return d.pc + offs16;
    endcase
endfunction

function automatic logic branch_outcome(input id_dispatch_t d);
    bus32_t a;
    bus32_t b;
    a = src_value(d.reg1_read_en, d.reg1_read_addr);
    b = operand_b(d);
    case (d.aluop)
        ALU_BEQ:  return a == b;
        ALU_BNE:  return a != b;
        ALU_BLT:  return $signed(a) < $signed(b);
        ALU_BGE:  return $signed(a) >= $signed(b);
        ALU_BLTU: return a < b;
        ALU_BGEU: return a >= b;
        default:  return 1'b1;  // B, BL and JIRL always jump.
    endcase
endfunction

function automatic logic model_pause(input id_dispatch_t d);
    if (!d.valid || !ex_load_valid || ex_load_dest == 5'd0) begin
        return 1'b0;
    end
    return (d.reg1_read_en && d.reg1_read_addr == ex_load_dest) ||
           (d.reg2_read_en && d.reg2_read_addr == ex_load_dest);
endfunction

task automatic model_branch(input id_dispatch_t d, input logic paused, output logic upd,
                            output logic taken, output logic flush, output bus32_t addr);
    upd   = d.valid && !paused && (d.aluop inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
             ALU_BLTU, ALU_BGEU, ALU_B, ALU_BL, ALU_JIRL});
    taken = 1'b0;
    flush = 1'b0;
    addr  = '0;
    if (upd) begin
        taken = branch_outcome(d);
        flush = (taken != d.pre_is_branch_taken) ||
                (taken && d.pre_branch_addr != branch_target(d));
        if (taken) begin
            addr = branch_target(d);
        end else if (d.pre_is_branch_taken) begin
            addr = d.pc + 32'd4;
        end
    end
endtask

// Executes one accepted instruction in program order.
task automatic model_step(input id_dispatch_t d, input logic paused, input int cycle);
    bus32_t    a;
    bus32_t    b;
    bus32_t    result;
    wb_entry_t entry;
    logic      accept;
    accept        = d.valid && !paused;
    ex_load_valid = accept && d.aluop == ALU_LDW && d.reg_write_en;
    ex_load_dest  = d.reg_write_addr;
    if (accept) begin
        a = src_value(d.reg1_read_en, d.reg1_read_addr);
        b = operand_b(d);
        case (d.aluop)
            ALU_ADD:          result = a + b;
            ALU_SUB:          result = a - b;
            ALU_AND:          result = a & b;
            ALU_OR:           result = a | b;
            ALU_XOR:          result = a ^ b;
            ALU_SLT:          result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:         result = (a < b) ? 32'd1 : 32'd0;
            ALU_PCADDU12I:    result = d.pc + b;
            ALU_LDW:          result = model_mem[word_index(a + d.imm)];
            ALU_STW: begin
                result = a + d.imm;
                model_mem[word_index(result)] = b;
            end
            ALU_BL, ALU_JIRL: result = d.pc + 32'd4;
            default:          result = '0;
        endcase
        if (d.reg_write_en) begin
            entry.due  = cycle + 3;
            entry.addr = d.reg_write_addr;
            entry.data = result;
            wb_queue.push_back(entry);
            if (d.reg_write_addr != 5'd0) begin
                model_regs[d.reg_write_addr] = result;
            end
        end
    end
endtask

`endif

/* test/tb_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend_top;
    import isa_pkg::*;
    import pipeline_pkg::*;

    localparam int          DATA_WORDS  = 64;
    localparam int          NUM_INSTS   = 2000;
    localparam int          PAUSE_LIMIT = 2;
    localparam int          DRAIN_LIMIT = 8;
    localparam int unsigned SEED        = 13;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      inst_valid;
    bus32_t    pc;
    bus32_t    inst;
    bus32_t    imm;
    alu_op_t   aluop;
    logic      reg1_read_en;
    logic      reg2_read_en;
    logic      reg_write_en;
    reg_addr_t reg1_read_addr;
    reg_addr_t reg2_read_addr;
    reg_addr_t reg_write_addr;
    logic      pre_is_branch_taken;
    bus32_t    pre_branch_addr;
    logic      pause_dispatch;
    logic      branch_update_en;
    logic      branch_taken;
    logic      branch_flush;
    bus32_t    branch_actual_addr;
    logic      wb_en;
    reg_addr_t wb_addr;
    bus32_t    wb_data;

    int unsigned lcg_state = SEED;
    alu_op_t     alu_ops [8] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
                                 ALU_SLTU, ALU_PCADDU12I};
    alu_op_t     branch_ops [9] = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU,
                                    ALU_BGEU, ALU_B, ALU_BL, ALU_JIRL};

    `include "backend_model.svh"

    backend_top #(.DATA_WORDS(DATA_WORDS)) u_backend_top (.*);

    always #20 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;  // Upper bits are the random ones.
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return lcg_next() % n;
    endfunction

    function automatic bus32_t rand_word();
        bus32_t hi;
        hi = lcg_next();
        return (hi << 16) | lcg_next();
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(rand_below(8));  // r0 to r7 keeps hazards frequent.
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first mismatch.");
    endtask

    task automatic check_word(input string name, input bus32_t got, input bus32_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic id_dispatch_t make_inst(input bus32_t at_pc);
        id_dispatch_t d;
        int unsigned  kind;
        d       = '0;
        d.pc    = at_pc;
        d.valid = rand_below(3) != 0;  // About a third are gaps.
        if (!d.valid) begin
            return d;
        end
        kind                  = rand_below(10);
        d.inst                = rand_word();
        d.imm                 = rand_word();
        d.reg1_read_en        = 1'b1;
        d.reg1_read_addr      = rand_reg();
        d.reg2_read_addr      = rand_reg();
        d.reg_write_addr      = rand_reg();
        d.pre_is_branch_taken = rand_below(2) != 0;
        if (kind < 4) begin
            d.aluop        = alu_ops[rand_below(8)];
            d.reg2_read_en = rand_below(2) != 0;
            d.reg_write_en = 1'b1;
            if (d.aluop == ALU_PCADDU12I) begin
                d.reg1_read_en = 1'b0;
                d.reg2_read_en = 1'b0;
            end
        end else if (kind < 8) begin
            // Small offsets plus whole RAM sizes give hits and aliases.
            d.aluop        = (kind < 6) ? ALU_LDW : ALU_STW;
            d.imm          = (rand_below(16) << 2) + rand_below(4) * DATA_WORDS * 4;
            d.reg2_read_en = d.aluop == ALU_STW;
            d.reg_write_en = d.aluop == ALU_LDW;
            if (rand_below(2) != 0) begin
                d.reg1_read_addr = 5'd0;
            end
        end else begin
            d.aluop        = branch_ops[rand_below(9)];
            d.reg1_read_en = !(d.aluop inside {ALU_B, ALU_BL});
            d.reg2_read_en = !(d.aluop inside {ALU_B, ALU_BL, ALU_JIRL});
            d.reg_write_en = d.aluop inside {ALU_BL, ALU_JIRL};
        end
        d.pre_branch_addr = (rand_below(2) != 0) ? branch_target(d) : rand_word() & ~32'd3;
        return d;
    endfunction

    task automatic drive_inputs(input id_dispatch_t d);
        inst_valid          <= d.valid;
        pc                  <= d.pc;
        inst                <= d.inst;
        imm                 <= d.imm;
        aluop               <= d.aluop;
        reg1_read_en        <= d.reg1_read_en;
        reg1_read_addr      <= d.reg1_read_addr;
        reg2_read_en        <= d.reg2_read_en;
        reg2_read_addr      <= d.reg2_read_addr;
        reg_write_en        <= d.reg_write_en;
        reg_write_addr      <= d.reg_write_addr;
        pre_is_branch_taken <= d.pre_is_branch_taken;
        pre_branch_addr     <= d.pre_branch_addr;
    endtask

    task automatic check_outputs(input id_dispatch_t d, input logic exp_pause, input int cycle);
        logic   upd;
        logic   taken;
        logic   flush;
        bus32_t target;
        model_branch(d, exp_pause, upd, taken, flush, target);
        check_bit("pause_dispatch", pause_dispatch, exp_pause);
        check_bit("branch_update_en", branch_update_en, upd);
        check_bit("branch_taken", branch_taken, taken);
        check_bit("branch_flush", branch_flush, flush);
        check_word("branch_actual_addr", branch_actual_addr, target);
        if (wb_queue.size() > 0 && wb_queue[0].due == cycle) begin
            check_bit("wb_en", wb_en, 1'b1);
            check_addr("wb_addr", wb_addr, wb_queue[0].addr);
            check_word("wb_data", wb_data, wb_queue[0].data);
            void'(wb_queue.pop_front());
        end else begin
            check_bit("wb_en", wb_en, 1'b0);
        end
    endtask

    initial begin
        id_dispatch_t cur;
        id_dispatch_t gap;
        bus32_t       next_pc;
        logic         exp_pause;
        int           cycle;
        int           held;
        int           waited;
        gap     = '0;
        rst_n   <= 1'b0;
        drive_inputs(gap);
        model_reset();
        next_pc = 32'h1c00_0000;
        cycle   = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_INSTS; n++) begin
            cur     = make_inst(next_pc);
            next_pc = next_pc + 32'd4;
            drive_inputs(cur);
            held    = 0;
            do begin
                @(negedge clk);  // Outputs are settled mid-cycle.
                exp_pause = model_pause(cur);
                check_outputs(cur, exp_pause, cycle);
                model_step(cur, exp_pause, cycle);
                cycle++;
                @(posedge clk);
                held = exp_pause ? held + 1 : 0;
                if (held > PAUSE_LIMIT) begin
                    $display("Timeout: instruction at pc %h held for %0d cycles", cur.pc, held);
                    stop_run();
                end
            end while (exp_pause);
        end
        drive_inputs(gap);
        waited = 0;
        while (wb_queue.size() > 0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("Timeout: %0d write-backs never appeared", wb_queue.size());
                stop_run();
            end
            @(negedge clk);
            check_outputs(gap, 1'b0, cycle);
            model_step(gap, 1'b0, cycle);
            cycle++;
            waited++;
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
    parameter int DATA_WORDS = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  isa_pkg::bus32_t     pc,
    input  isa_pkg::bus32_t     inst,
    input  isa_pkg::bus32_t     imm,
    input  isa_pkg::alu_op_t    aluop,
    input  logic                reg1_read_en,
    input  logic                reg2_read_en,
    input  logic                reg_write_en,
    input  isa_pkg::reg_addr_t  reg1_read_addr,
    input  isa_pkg::reg_addr_t  reg2_read_addr,
    input  isa_pkg::reg_addr_t  reg_write_addr,
    input  logic                pre_is_branch_taken,
    input  isa_pkg::bus32_t     pre_branch_addr,
    output logic                pause_dispatch,
    output logic                branch_update_en,
    output logic                branch_taken,
    output logic                branch_flush,
    output isa_pkg::bus32_t     branch_actual_addr,
    output logic                wb_en,
    output isa_pkg::reg_addr_t  wb_addr,
    output isa_pkg::bus32_t     wb_data
);
    import isa_pkg::*;
    import pipeline_pkg::*;

    id_dispatch_t   id_dispatch;
    dispatch_ex_t   dispatch_ex;
    dispatch_ex_t   ex_mem;
    push_forward_t  ex_push_forward;
    push_forward_t  mem_push_forward;
    push_forward_t  wb;
    branch_update_t branch_update_info;
    alu_op_t        ex_aluop;

    dispatch_regfile_if rf_if ();

    assign id_dispatch = '{
        valid: inst_valid, pc: pc, inst: inst, aluop: aluop, imm: imm,
        reg1_read_en: reg1_read_en, reg1_read_addr: reg1_read_addr,
        reg2_read_en: reg2_read_en, reg2_read_addr: reg2_read_addr,
        reg_write_en: reg_write_en, reg_write_addr: reg_write_addr,
        pre_is_branch_taken: pre_is_branch_taken, pre_branch_addr: pre_branch_addr
    };

    dispatch u_dispatch (
        .id_dispatch        (id_dispatch),
        .ex_push_forward    (ex_push_forward),
        .mem_push_forward   (mem_push_forward),
        .ex_aluop           (ex_aluop),
        .master             (rf_if.master),
        .pause_dispatch     (pause_dispatch),
        .dispatch_ex        (dispatch_ex),
        .branch_update_info (branch_update_info)
    );

    execute u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .dispatch_ex     (dispatch_ex),
        .ex_aluop        (ex_aluop),
        .ex_push_forward (ex_push_forward),
        .ex_mem          (ex_mem)
    );

    mem_stage #(.DATA_WORDS(DATA_WORDS)) u_mem_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_mem           (ex_mem),
        .mem_push_forward (mem_push_forward),
        .wb               (wb)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (rf_if.slave),
        .wb    (wb)
    );

    assign branch_update_en   = branch_update_info.update_en;
    assign branch_taken       = branch_update_info.taken_or_not_actual;
    assign branch_flush       = branch_update_info.branch_flush;
    assign branch_actual_addr = branch_update_info.branch_actual_addr;

    assign wb_en   = wb.reg_write_en;
    assign wb_addr = wb.reg_write_addr;
    assign wb_data = wb.reg_write_data;

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int DATA_WORDS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pipeline_pkg::dispatch_ex_t  ex_mem,
    output pipeline_pkg::push_forward_t mem_push_forward,
    output pipeline_pkg::push_forward_t wb
);
    import isa_pkg::*;
    import pipeline_pkg::*;

    dispatch_ex_t mem_q;
    bus32_t       ram [DATA_WORDS];
    bus32_t       word_idx;
    bus32_t       load_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_q.valid <= 1'b0;
        end else begin
            mem_q <= ex_mem;
        end
    end

    assign word_idx  = (mem_q.reg1 >> 2) % DATA_WORDS;  // Aliases wrap around.
    assign load_data = ram[word_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (mem_q.valid && mem_q.aluop == ALU_STW) begin
            ram[word_idx] <= mem_q.reg2;
        end
    end

    assign mem_push_forward.reg_write_en   = mem_q.valid && mem_q.reg_write_en;
    assign mem_push_forward.reg_write_addr = mem_q.reg_write_addr;
    assign mem_push_forward.reg_write_data = (mem_q.aluop == ALU_LDW) ? load_data : mem_q.reg1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.reg_write_en <= 1'b0;
        end else begin
            wb <= mem_push_forward;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pipeline_pkg::dispatch_ex_t  dispatch_ex,
    output isa_pkg::alu_op_t            ex_aluop,
    output pipeline_pkg::push_forward_t ex_push_forward,
    output pipeline_pkg::dispatch_ex_t  ex_mem
);
    import isa_pkg::*;
    import pipeline_pkg::*;

    dispatch_ex_t ex_q;
    bus32_t       result;

    // Only the valid bit is cleared by reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= dispatch_ex;
        end
    end

    always_comb begin
        case (ex_q.aluop)
            ALU_ADD:           result = ex_q.reg1 + ex_q.reg2;
            ALU_SUB:           result = ex_q.reg1 - ex_q.reg2;
            ALU_AND:           result = ex_q.reg1 & ex_q.reg2;
            ALU_OR:            result = ex_q.reg1 | ex_q.reg2;
            ALU_XOR:           result = ex_q.reg1 ^ ex_q.reg2;
            ALU_SLT:           result = {31'b0, $signed(ex_q.reg1) < $signed(ex_q.reg2)};
            ALU_SLTU:          result = {31'b0, ex_q.reg1 < ex_q.reg2};
            ALU_PCADDU12I:     result = ex_q.reg1 + ex_q.reg2;  // The pc arrives in reg1.
            ALU_LDW, ALU_STW:  result = ex_q.reg1 + ex_q.imm;  // Effective address.
            ALU_BL, ALU_JIRL:  result = ex_q.reg_write_branch_data;
            default:           result = '0;
        endcase
    end

    assign ex_aluop = ex_q.valid ? ex_q.aluop : ALU_NOP;

    assign ex_push_forward.reg_write_en   = ex_q.valid && ex_q.reg_write_en;
    assign ex_push_forward.reg_write_addr = ex_q.reg_write_addr;
    assign ex_push_forward.reg_write_data = result;

    always_comb begin
        ex_mem      = ex_q;
        ex_mem.reg1 = result;  // Store data stays in reg2.
    end

    a_nop_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_q.valid && ex_q.aluop == ALU_NOP) |-> !ex_q.reg_write_en);

endmodule

`default_nettype wire

/* hdl/dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  pipeline_pkg::id_dispatch_t   id_dispatch,
    input  pipeline_pkg::push_forward_t  ex_push_forward,
    input  pipeline_pkg::push_forward_t  mem_push_forward,
    input  isa_pkg::alu_op_t             ex_aluop,
    dispatch_regfile_if.master           master,
    output logic                         pause_dispatch,
    output pipeline_pkg::dispatch_ex_t   dispatch_ex,
    output pipeline_pkg::branch_update_t branch_update_info
);
    import isa_pkg::*;
    import pipeline_pkg::*;

    bus32_t op1;
    bus32_t op2;
    bus32_t offs16_ext;
    bus32_t offs26_ext;
    bus32_t pc_plus4;
    bus32_t branch_target_addr;
    logic   is_branch;
    logic   is_branch_taken;
    logic   update_en;

    // A source matches a pending result; r0 never forwards.
    function automatic logic fwd_hit(input push_forward_t fwd, input logic en,
                                     input reg_addr_t addr);
        return en && fwd.reg_write_en && fwd.reg_write_addr == addr && addr != '0;
    endfunction

    function automatic bus32_t operand(input logic en, input reg_addr_t addr,
                                       input bus32_t rf_data);
        if (fwd_hit(ex_push_forward, en, addr)) begin
            return ex_push_forward.reg_write_data;
        end else if (fwd_hit(mem_push_forward, en, addr)) begin
            return mem_push_forward.reg_write_data;
        end
        return rf_data;
    endfunction

    assign master.reg1_read_en   = id_dispatch.reg1_read_en;
    assign master.reg1_read_addr = id_dispatch.reg1_read_addr;
    assign master.reg2_read_en   = id_dispatch.reg2_read_en;
    assign master.reg2_read_addr = id_dispatch.reg2_read_addr;

    assign pause_dispatch = id_dispatch.valid && ex_aluop == ALU_LDW &&
        (fwd_hit(ex_push_forward, id_dispatch.reg1_read_en, id_dispatch.reg1_read_addr) ||
         fwd_hit(ex_push_forward, id_dispatch.reg2_read_en, id_dispatch.reg2_read_addr));

    assign offs16_ext = {{14{id_dispatch.inst[OFFS16_HI]}},
                         id_dispatch.inst[OFFS16_HI:OFFS16_LO], 2'b00};
    assign offs26_ext = {{4{id_dispatch.inst[OFFS26_HI]}}, id_dispatch.inst[OFFS26_HI:OFFS26_LO],
                         id_dispatch.inst[OFFS16_HI:OFFS16_LO], 2'b00};
    assign pc_plus4   = id_dispatch.pc + 32'd4;

    always_comb begin
        op1 = operand(id_dispatch.reg1_read_en, id_dispatch.reg1_read_addr,
                      master.reg1_read_data);
        if (id_dispatch.aluop == ALU_PCADDU12I) begin
            op1 = id_dispatch.pc;
        end
        op2 = operand(id_dispatch.reg2_read_en, id_dispatch.reg2_read_addr,
                      master.reg2_read_data);
        if (!id_dispatch.reg2_read_en) begin
            op2 = id_dispatch.imm;
        end
    end

    always_comb begin
        is_branch          = 1'b1;
        is_branch_taken    = 1'b1;
        branch_target_addr = id_dispatch.pc + offs16_ext;
        case (id_dispatch.aluop)
            ALU_BEQ:  is_branch_taken = op1 == op2;
            ALU_BNE:  is_branch_taken = op1 != op2;
            ALU_BLT:  is_branch_taken = $signed(op1) < $signed(op2);
            ALU_BGE:  is_branch_taken = $signed(op1) >= $signed(op2);
            ALU_BLTU: is_branch_taken = op1 < op2;
            ALU_BGEU: is_branch_taken = op1 >= op2;
            ALU_B, ALU_BL: branch_target_addr = id_dispatch.pc + offs26_ext;
            ALU_JIRL: branch_target_addr = op1 + offs16_ext;
            default: begin
                is_branch       = 1'b0;
                is_branch_taken = 1'b0;
            end
        endcase
    end

    assign update_en = id_dispatch.valid && !pause_dispatch && is_branch;

    always_comb begin
        dispatch_ex.valid          = id_dispatch.valid && !pause_dispatch;  // Bubble on pause.
        dispatch_ex.pc             = id_dispatch.pc;
        dispatch_ex.aluop          = id_dispatch.aluop;
        dispatch_ex.reg1           = op1;
        dispatch_ex.reg2           = op2;
        dispatch_ex.imm            = id_dispatch.imm;
        dispatch_ex.reg_write_en   = id_dispatch.reg_write_en;
        dispatch_ex.reg_write_addr = id_dispatch.reg_write_addr;
        dispatch_ex.reg_write_branch_data = '0;
        if (id_dispatch.aluop == ALU_BL || id_dispatch.aluop == ALU_JIRL) begin
            dispatch_ex.reg_write_branch_data = pc_plus4;
        end
    end

    always_comb begin
        branch_update_info             = '0;
        branch_update_info.pc_dispatch = id_dispatch.pc;
        if (update_en) begin
            branch_update_info.update_en           = 1'b1;
            branch_update_info.taken_or_not_actual = is_branch_taken;
            branch_update_info.branch_flush =
                (is_branch_taken != id_dispatch.pre_is_branch_taken) ||
                (is_branch_taken && id_dispatch.pre_branch_addr != branch_target_addr);
            if (is_branch_taken) begin
                branch_update_info.branch_actual_addr = branch_target_addr;
            end else if (id_dispatch.pre_is_branch_taken) begin
                branch_update_info.branch_actual_addr = pc_plus4;  // Recover fall-through.
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    dispatch_regfile_if.slave          port,
    input  pipeline_pkg::push_forward_t wb
);
    import isa_pkg::*;

    bus32_t regs [1:31];

    // Write-through so a reader in the write-back cycle sees the new value.
    function automatic bus32_t read_port(input logic en, input reg_addr_t addr);
        if (!en || addr == '0) begin
            return '0;
        end else if (wb.reg_write_en && wb.reg_write_addr == addr) begin
            return wb.reg_write_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write_en && wb.reg_write_addr != '0) begin
            regs[wb.reg_write_addr] <= wb.reg_write_data;
        end
    end

    always_comb begin
        port.reg1_read_data = read_port(port.reg1_read_en, port.reg1_read_addr);
        port.reg2_read_data = read_port(port.reg2_read_en, port.reg2_read_addr);
    end

    // A register reads back what was written to it one cycle earlier.
    a_write_read_back: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.reg_write_en && wb.reg_write_addr != '0) |=>
        (!port.reg1_read_en || port.reg1_read_addr != $past(wb.reg_write_addr) ||
         (wb.reg_write_en && wb.reg_write_addr == port.reg1_read_addr) ||
         port.reg1_read_data == $past(wb.reg_write_data)));

endmodule

`default_nettype wire

/* hdl/dispatch_regfile_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dispatch_regfile_if;
    import isa_pkg::*;

    logic      reg1_read_en;
    reg_addr_t reg1_read_addr;
    bus32_t    reg1_read_data;
    logic      reg2_read_en;
    reg_addr_t reg2_read_addr;
    bus32_t    reg2_read_data;

    modport master (
        output reg1_read_en, reg1_read_addr, reg2_read_en, reg2_read_addr,
        input  reg1_read_data, reg2_read_data
    );

    modport slave (
        input  reg1_read_en, reg1_read_addr, reg2_read_en, reg2_read_addr,
        output reg1_read_data, reg2_read_data
    );

endinterface

`default_nettype wire

/* hdl/pipeline_pkg.sv */
`default_nettype none

package pipeline_pkg;

    // Decoded instruction from the front end.
    typedef struct packed {
        logic                valid;
        isa_pkg::bus32_t     pc;
        isa_pkg::bus32_t     inst;
        isa_pkg::alu_op_t    aluop;
        isa_pkg::bus32_t     imm;
        logic                reg1_read_en;
        isa_pkg::reg_addr_t  reg1_read_addr;
        logic                reg2_read_en;
        isa_pkg::reg_addr_t  reg2_read_addr;
        logic                reg_write_en;
        isa_pkg::reg_addr_t  reg_write_addr;
        logic                pre_is_branch_taken;
        isa_pkg::bus32_t     pre_branch_addr;
    } id_dispatch_t;

    // Issued instruction with resolved operands.
    typedef struct packed {
        logic                valid;
        isa_pkg::bus32_t     pc;
        isa_pkg::alu_op_t    aluop;
        isa_pkg::bus32_t     reg1;
        isa_pkg::bus32_t     reg2;
        isa_pkg::bus32_t     imm;
        logic                reg_write_en;
        isa_pkg::reg_addr_t  reg_write_addr;
        isa_pkg::bus32_t     reg_write_branch_data;
    } dispatch_ex_t;

    typedef struct packed {
        logic                reg_write_en;
        isa_pkg::reg_addr_t  reg_write_addr;
        isa_pkg::bus32_t     reg_write_data;
    } push_forward_t;

    typedef struct packed {
        logic                update_en;
        logic                taken_or_not_actual;
        logic                branch_flush;
        isa_pkg::bus32_t     branch_actual_addr;
        isa_pkg::bus32_t     pc_dispatch;
    } branch_update_t;

endpackage

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0] {
        ALU_NOP       = 6'h00,
        ALU_ADD       = 6'h01,
        ALU_SUB       = 6'h02,
        ALU_AND       = 6'h03,
        ALU_OR        = 6'h04,
        ALU_XOR       = 6'h05,
        ALU_SLT       = 6'h06,
        ALU_SLTU      = 6'h07,
        ALU_PCADDU12I = 6'h08,
        ALU_LDW       = 6'h10,
        ALU_STW       = 6'h11,
        ALU_BEQ       = 6'h20,
        ALU_BNE       = 6'h21,
        ALU_BLT       = 6'h22,
        ALU_BGE       = 6'h23,
        ALU_BLTU      = 6'h24,
        ALU_BGEU      = 6'h25,
        ALU_B         = 6'h26,
        ALU_BL        = 6'h27,
        ALU_JIRL      = 6'h28
    } alu_op_t;

    // Branch offset fields in the instruction word.
    localparam int OFFS16_HI = 25;
    localparam int OFFS16_LO = 10;
    localparam int OFFS26_HI = 9;  // Upper ten bits of offs26.
    localparam int OFFS26_LO = 0;

endpackage

`default_nettype wire
